// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f eth_tx_mac.f \
		--top-module eth_tx_mac_tb -o eth_tx_mac_sim
	./obj_dir/eth_tx_mac_sim | awk '{ print } /^Simulation completed successfully$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== eth_tx_mac.f ====
+incdir+tb
source/eth_tx_pkg.sv
source/tx_packet_buffer.sv
source/tx_framer.sv
source/tx_fcs_insert.sv
source/eth_tx_mac.sv
tb/eth_tx_mac_tb.sv

// ==== source/eth_tx_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module eth_tx_mac
    import eth_tx_pkg::*;
#(
    parameter int SLOT_COUNT = 4,
    parameter int MAX_LEN    = 64,
    parameter int GAP_CYCLES = 12
) (
    input  wire         clock,
    input  wire         reset,
    input  wire         wr_valid,
    input  wire [7:0]   wr_data,
    input  wire         wr_last,
    output logic        credit_return,
    output logic [7:0]  gmii_txd,
    output logic        gmii_tx_en
);

    localparam int IDX_W = $clog2(MAX_LEN);
    localparam int LEN_W = $clog2(MAX_LEN + 1);

    logic             pkt_avail;
    logic [LEN_W-1:0] pkt_len;
    logic [IDX_W-1:0] rd_index;
    logic [7:0]       rd_data;
    logic             pkt_done;
    tx_phase_t        st_phase;
    logic [7:0]       st_byte;

    tx_packet_buffer #(
        .SLOT_COUNT (SLOT_COUNT),
        .MAX_LEN    (MAX_LEN)
    ) u_buffer (
        .clock         (clock),
        .reset         (reset),
        .wr_valid      (wr_valid),
        .wr_data       (wr_data),
        .wr_last       (wr_last),
        .rd_index      (rd_index),
        .pkt_done      (pkt_done),
        .pkt_avail     (pkt_avail),
        .pkt_len       (pkt_len),
        .rd_data       (rd_data),
        .credit_return (credit_return)
    );

    tx_framer #(
        .MAX_LEN    (MAX_LEN),
        .GAP_CYCLES (GAP_CYCLES)
    ) u_framer (
        .clock     (clock),
        .reset     (reset),
        .pkt_avail (pkt_avail),
        .pkt_len   (pkt_len),
        .rd_data   (rd_data),
        .rd_index  (rd_index),
        .pkt_done  (pkt_done),
        .st_phase  (st_phase),
        .st_byte   (st_byte)
    );

    tx_fcs_insert u_fcs (
        .clock      (clock),
        .reset      (reset),
        .st_phase   (st_phase),
        .st_byte    (st_byte),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

endmodule

`default_nettype wire

// ==== source/eth_tx_pkg.sv ====
`default_nettype none

package eth_tx_pkg;

    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hD5;
    localparam int          PREAMBLE_LEN  = 7;
    localparam int          FCS_LEN       = 4;
    localparam logic [31:0] CRC_INIT      = 32'hFFFF_FFFF;

    // tags each byte on the framer to fcs stream
    typedef enum logic [2:0] {
        phase_idle,
        phase_preamble,
        phase_sfd,
        phase_data,
        phase_fcs
    } tx_phase_t;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_sfd,
        st_data,
        st_fcs,
        st_gap
    } framer_state_t;

    // reflected crc-32, one byte, lsb first
    function automatic logic [31:0] crc32_next(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'h00_0000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== source/tx_fcs_insert.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_fcs_insert
    import eth_tx_pkg::*;
(
    input  wire             clock,
    input  wire             reset,
    input  wire tx_phase_t  st_phase,
    input  wire [7:0]       st_byte,
    output logic [7:0]      gmii_txd,
    output logic            gmii_tx_en
);

    logic [31:0] crc;
    logic [31:0] fcs_word;
    logic [1:0]  fcs_idx;  // which fcs byte goes out next

    assign fcs_word = ~crc;

    always_ff @(posedge clock) begin
        case (st_phase)
            phase_sfd:  crc <= CRC_INIT;
            phase_data: crc <= crc32_next(crc, st_byte);
            default:    crc <= crc;  // held through fcs
        endcase
    end

    always_ff @(posedge clock) begin
        case (st_phase)
            phase_idle: gmii_txd <= 8'h00;
            phase_fcs:  gmii_txd <= fcs_word[{fcs_idx, 3'b000} +: 8];  // lsb first
            default:    gmii_txd <= st_byte;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fcs_idx    <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            gmii_tx_en <= (st_phase != phase_idle);
            if (st_phase == phase_fcs) begin
                fcs_idx <= fcs_idx + 1'b1;
            end else begin
                fcs_idx <= '0;
            end
        end
    end

    // fcs run from the framer must be exactly four bytes
    assert property (@(posedge clock) disable iff (reset)
        (st_phase == phase_fcs && fcs_idx == 2'd3) |=> st_phase != phase_fcs)
        else $error("fcs phase longer than four cycles");

    assert property (@(posedge clock) disable iff (reset)
        (st_phase == phase_fcs && fcs_idx != 2'd3) |=> st_phase == phase_fcs)
        else $error("fcs phase shorter than four cycles");

endmodule

`default_nettype wire

// ==== source/tx_framer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_framer
    import eth_tx_pkg::*;
#(
    parameter int MAX_LEN    = 64,
    parameter int GAP_CYCLES = 12
) (
    input  wire                               clock,
    input  wire                               reset,
    input  wire                               pkt_avail,
    input  wire [$clog2(MAX_LEN + 1)-1:0]     pkt_len,
    input  wire [7:0]                         rd_data,
    output logic [$clog2(MAX_LEN)-1:0]        rd_index,
    output logic                              pkt_done,
    output tx_phase_t                         st_phase,
    output logic [7:0]                        st_byte
);

    localparam int IDX_W   = $clog2(MAX_LEN);
    localparam int CNT_MAX = (MAX_LEN > GAP_CYCLES) ? MAX_LEN : GAP_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    framer_state_t    state;
    logic [CNT_W-1:0] cnt;    // shared by every timed state
    logic [CNT_W-1:0] len_q;
    logic             last_data;

    assign last_data = (cnt == len_q - 1'b1);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (pkt_avail) begin
                        state <= st_preamble;
                    end
                end
                st_preamble: begin
                    if (cnt == CNT_W'(PREAMBLE_LEN - 1)) begin
                        state <= st_sfd;
                        cnt   <= '0;
                    end
                end
                st_sfd: begin
                    state <= st_data;
                    cnt   <= '0;
                end
                st_data: begin
                    if (last_data) begin
                        state <= st_fcs;
                        cnt   <= '0;
                    end
                end
                st_fcs: begin
                    if (cnt == CNT_W'(FCS_LEN - 1)) begin
                        state <= st_gap;
                        cnt   <= '0;
                    end
                end
                st_gap: begin
                    if (cnt == CNT_W'(GAP_CYCLES - 1)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle && pkt_avail) begin
            len_q <= CNT_W'(pkt_len);
        end
    end

    // index 0 goes out during sfd so data follows with no bubble
    assign rd_index = (state == st_data) ? cnt[IDX_W-1:0] + 1'b1 : '0;
    assign pkt_done = (state == st_data) && last_data;

    always_comb begin
        st_phase = phase_idle;
        st_byte  = 8'h00;
        case (state)
            st_preamble: begin
                st_phase = phase_preamble;
                st_byte  = PREAMBLE_BYTE;
            end
            st_sfd: begin
                st_phase = phase_sfd;
                st_byte  = SFD_BYTE;
            end
            st_data: begin
                st_phase = phase_data;
                st_byte  = rd_data;
            end
            st_fcs:  st_phase = phase_fcs;  // byte replaced downstream
            default: st_phase = phase_idle;
        endcase
    end

    // the slot being released must still be committed
    assert property (@(posedge clock) disable iff (reset)
        pkt_done |-> pkt_avail)
        else $error("pkt_done with no committed slot");

    assert property (@(posedge clock) disable iff (reset)
        (state == st_idle && pkt_avail) |-> pkt_len != '0)
        else $error("committed slot with zero length");

endmodule

`default_nettype wire

// ==== source/tx_packet_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_packet_buffer #(
    parameter int SLOT_COUNT = 4,
    parameter int MAX_LEN    = 64
) (
    input  wire                               clock,
    input  wire                               reset,
    input  wire                               wr_valid,
    input  wire [7:0]                         wr_data,
    input  wire                               wr_last,
    input  wire [$clog2(MAX_LEN)-1:0]         rd_index,
    input  wire                               pkt_done,
    output logic                              pkt_avail,
    output logic [$clog2(MAX_LEN + 1)-1:0]    pkt_len,
    output logic [7:0]                        rd_data,
    output logic                              credit_return
);

    localparam int SLOT_W = $clog2(SLOT_COUNT);
    localparam int IDX_W  = $clog2(MAX_LEN);
    localparam int LEN_W  = $clog2(MAX_LEN + 1);

    logic [7:0]        mem     [SLOT_COUNT][MAX_LEN];
    logic [LEN_W-1:0]  len_mem [SLOT_COUNT];
    logic [SLOT_W-1:0] wr_slot;
    logic [SLOT_W-1:0] rd_slot;
    logic [LEN_W-1:0]  wr_count;   // bytes written into current slot
    logic [SLOT_W:0]   occupancy;  // committed slots not yet freed
    logic              commit;

    assign commit = wr_valid && wr_last;

    always_ff @(posedge clock) begin
        if (wr_valid) begin
            mem[wr_slot][wr_count[IDX_W-1:0]] <= wr_data;
        end
        if (commit) begin
            len_mem[wr_slot] <= wr_count + 1'b1;
        end
        rd_data <= mem[rd_slot][rd_index];  // oldest committed slot
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_slot       <= '0;
            rd_slot       <= '0;
            wr_count      <= '0;
            occupancy     <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pkt_done;
            if (wr_valid) begin
                wr_count <= wr_last ? '0 : wr_count + 1'b1;
            end
            if (commit) begin
                wr_slot <= wr_slot + 1'b1;  // wraps, slot count is a power of two
            end
            if (pkt_done) begin
                rd_slot <= rd_slot + 1'b1;
            end
            case ({commit, pkt_done})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign pkt_avail = (occupancy != '0);
    assign pkt_len   = len_mem[rd_slot];

    // host only starts a packet while it holds a credit
    assert property (@(posedge clock) disable iff (reset)
        (wr_valid && wr_count == '0) |-> occupancy < (SLOT_W + 1)'(SLOT_COUNT))
        else $error("packet started with every slot occupied");

    // packets longer than MAX_LEN would overrun the slot
    assert property (@(posedge clock) disable iff (reset)
        wr_count < LEN_W'(MAX_LEN))
        else $error("write byte counter reached MAX_LEN");

endmodule

`default_nettype wire

// ==== tb/eth_tx_model.svh ====
`ifndef ETH_TX_MODEL_SVH
`define ETH_TX_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

// crc-32 bit by bit over a whole packet, already inverted
function automatic logic [31:0] ref_crc(input byte_q_t data);
    logic [31:0] crc;
    logic        fb;
    int          j;
    crc = 32'hFFFF_FFFF;
    foreach (data[i]) begin
        for (j = 0; j < 8; j++) begin
            fb  = crc[0] ^ data[i][j];  // lsb of each byte first
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ 32'hEDB8_8320;
            end
        end
    end
    return ~crc;
endfunction

// preamble, sfd, payload, fcs low byte first
function automatic byte_q_t expected_frame(input byte_q_t pkt);
    byte_q_t     frame;
    logic [31:0] fcs;
    int          k;
    frame = {};
    for (k = 0; k < 7; k++) begin
        frame.push_back(8'h55);
    end
    frame.push_back(8'hD5);
    foreach (pkt[i]) begin
        frame.push_back(pkt[i]);
    end
    fcs = ref_crc(pkt);
    for (k = 0; k < 4; k++) begin
        frame.push_back(fcs[8*k +: 8]);
    end
    return frame;
endfunction

`endif

// ==== tb/eth_tx_mac_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module eth_tx_mac_tb;

    localparam int SLOT_COUNT      = 4;
    localparam int MAX_LEN         = 64;
    localparam int GAP_CYCLES      = 12;
    localparam int RANDOM_PKTS     = 20;
    localparam int BURST_PKTS      = 2 * SLOT_COUNT;
    localparam int TOTAL_PKTS      = 1 + RANDOM_PKTS + 1 + BURST_PKTS;
    localparam int WATCHDOG_CYCLES = TOTAL_PKTS * (MAX_LEN + 30) + 200;

    `include "eth_tx_model.svh"

    logic       clock;
    logic       reset;
    logic       wr_valid;
    logic [7:0] wr_data;
    logic       wr_last;
    wire        credit_return;
    wire  [7:0] gmii_txd;
    wire        gmii_tx_en;

    integer     seed;
    int         errors;
    int         credits;         // host view of free slots
    int         returns_seen;
    int         frames_checked;
    bit         exhausted;
    logic [7:0] exp_data[$];     // queued payload bytes, oldest first
    int         exp_len[$];
    string      exp_name[$];

    eth_tx_mac #(
        .SLOT_COUNT (SLOT_COUNT),
        .MAX_LEN    (MAX_LEN),
        .GAP_CYCLES (GAP_CYCLES)
    ) DUT (
        .clock         (clock),
        .reset         (reset),
        .wr_valid      (wr_valid),
        .wr_data       (wr_data),
        .wr_last       (wr_last),
        .credit_return (credit_return),
        .gmii_txd      (gmii_txd),
        .gmii_tx_en    (gmii_tx_en)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // one host cycle, returned credits are picked up here
    task automatic tick();
        @(negedge clock);
        if (credit_return) begin
            credits++;
            returns_seen++;
        end
        if (credits > SLOT_COUNT) begin
            errors++;
            $display("host holds %0d credits but there are only %0d slots", credits, SLOT_COUNT);
        end
    endtask

    function automatic byte_q_t random_packet(input int len);
        byte_q_t pkt;
        int      i;
        pkt = {};
        for (i = 0; i < len; i++) begin
            pkt.push_back(8'($random(seed)));
        end
        return pkt;
    endfunction

    task automatic send_packet(input string name, input byte_q_t pkt);
        int i;
        tick();
        while (credits == 0) begin
            wr_valid = 1'b0;
            wr_last  = 1'b0;
            tick();
        end
        credits--;
        if (credits == 0) begin
            exhausted = 1'b1;
        end
        exp_len.push_back(pkt.size());
        exp_name.push_back(name);
        for (i = 0; i < pkt.size(); i++) begin
            if (i > 0) begin
                tick();
            end
            exp_data.push_back(pkt[i]);
            wr_valid = 1'b1;
            wr_data  = pkt[i];
            wr_last  = (i == pkt.size() - 1);
        end
    endtask

    task automatic compare_frame(input byte_q_t got);
        byte_q_t pkt;
        byte_q_t want;
        string   name;
        int      len;
        int      i;
        if (exp_len.size() == 0) begin
            errors++;
            $display("frame of %0d bytes sent with no packet queued", got.size());
            return;
        end
        len  = exp_len.pop_front();
        name = exp_name.pop_front();
        pkt  = {};
        for (i = 0; i < len; i++) begin
            pkt.push_back(exp_data.pop_front());
        end
        want = expected_frame(pkt);
        if (got.size() != 12 + len) begin
            errors++;
            $display("%s: tx_en high for %0d cycles instead of %0d", name, got.size(), 12 + len);
        end
        for (i = 0; i < want.size() && i < got.size(); i++) begin
            if (got[i] !== want[i]) begin
                errors++;
                $display("[ERROR] %s frame %0d byte %0d: expected %02h, actual %02h",
                         name, frames_checked, i, want[i], got[i]);
            end
        end
        frames_checked++;
    endtask

    // gmii monitor
    initial begin
        byte_q_t burst;
        int      idle_count;
        bit      in_burst;
        burst      = {};
        idle_count = 0;
        in_burst   = 1'b0;
        wait (reset === 1'b0);
        forever begin
            @(negedge clock);
            if (gmii_tx_en === 1'b1) begin
                if (!in_burst && frames_checked > 0 && idle_count < GAP_CYCLES) begin
                    errors++;
                    $display("only %0d idle cycles between frames, at least %0d required",
                             idle_count, GAP_CYCLES);
                end
                in_burst = 1'b1;
                burst.push_back(gmii_txd);
            end else begin
                if (in_burst) begin
                    compare_frame(burst);
                    burst      = {};
                    in_burst   = 1'b0;
                    idle_count = 0;
                end
                idle_count++;
            end
        end
    end

    initial begin
        byte_q_t     pkt;
        logic [31:0] check_crc;
        int          n;
        int          len;
        seed           = 63;
        errors         = 0;
        credits        = SLOT_COUNT;
        returns_seen   = 0;
        frames_checked = 0;
        exhausted      = 1'b0;
        reset          = 1'b1;
        wr_valid       = 1'b0;
        wr_data        = 8'h00;
        wr_last        = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        if (gmii_tx_en !== 1'b0 || credit_return !== 1'b0) begin
            errors++;
            $display("tx_en or credit_return not low after reset");
        end
        reset = 1'b0;

        // standard check string "123456789"
        pkt = {};
        for (n = 0; n < 9; n++) begin
            pkt.push_back(8'(8'h31 + n));
        end
        check_crc = ref_crc(pkt);
        if (check_crc !== 32'hCBF4_3926) begin
            errors++;
            $display("[ERROR] crc_model: expected %08h, actual %08h", 32'hCBF4_3926, check_crc);
        end

        pkt = {};
        pkt.push_back(8'hA5);
        send_packet("single_byte", pkt);
        for (n = 0; n < RANDOM_PKTS; n++) begin
            len = 1 + int'($unsigned($random(seed)) % MAX_LEN);
            send_packet("random_len", random_packet(len));
        end
        send_packet("max_len", random_packet(MAX_LEN));
        for (n = 0; n < BURST_PKTS; n++) begin
            send_packet("credit_burst", random_packet(8));
        end
        tick();
        wr_valid = 1'b0;
        wr_last  = 1'b0;

        while (frames_checked < TOTAL_PKTS) begin
            tick();
        end
        repeat (GAP_CYCLES + 4) tick();  // catch any stray frame

        if (returns_seen != frames_checked) begin
            errors++;
            $display("%0d credit returns for %0d frames", returns_seen, frames_checked);
        end
        if (credits != SLOT_COUNT) begin
            errors++;
            $display("host holds %0d credits at the end instead of %0d", credits, SLOT_COUNT);
        end
        if (!exhausted) begin
            errors++;
            $display("host never ran out of credits");
        end
        $display("errors: %0d, frames checked: %0d, credit returns: %0d",
                 errors, frames_checked, returns_seen);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout after %0d cycles with %0d of %0d frames checked",
                 WATCHDOG_CYCLES, frames_checked, TOTAL_PKTS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
